// ==== verification/shift_unit_golden.txt ====
# Columns in hex: dir(0 left,1 right) datasize(0=8,1=16,2=32) a b flags_in result flags
# Expected flag bits CF=001 PF=004 ZF=040 SF=080 OF=800
0 0 123456b5 00000001 00000fd5 0000006a 00000805
0 0 000000b5 00000007 00000fd5 00000080 00000880
0 0 000000b5 00000008 00000fd5 00000000 00000845
0 0 000000b5 00000009 00000fd5 00000000 00000844
1 0 000000b5 00000001 00000fd5 000000da 00000081
1 0 000000b5 00000007 00000fd5 000000ff 00000084
1 0 000000b5 00000008 00000fd5 000000ff 00000085
1 0 000000b5 0000000c 00000fd5 000000ff 00000085
1 0 0000004c 00000003 00000fd5 00000009 00000005
1 0 0000004c 00000008 00000fd5 00000000 00000044
0 0 0000004c 00000003 00000fd5 00000060 00000804
1 0 ffffff7f 00000001 00000fd5 0000003f 00000005
0 1 0000c003 00000001 00000fd5 00008006 00000085
0 1 0000c003 0000000f 00000fd5 00008000 00000085
0 1 0000c003 00000010 00000fd5 00000000 00000045
0 1 0000c003 00000014 00000fd5 00000000 00000044
0 1 ffff1234 00000024 00000fd5 00002340 00000001
1 1 00008421 00000001 00000fd5 0000c210 00000081
1 1 00008421 0000000f 00000fd5 0000ffff 00000084
1 1 00008421 00000010 00000fd5 0000ffff 00000085
1 1 00008421 0000001f 00000fd5 0000ffff 00000085
1 1 00007f00 00000008 00000fd5 0000007f 00000000
1 1 00007f00 00000011 00000fd5 00000000 00000044
0 2 80000001 00000001 00000fd5 00000002 00000801
0 2 80000001 0000001f 00000fd5 80000000 00000884
0 2 40000000 00000002 00000fd5 00000000 00000845
0 2 12345678 00000004 00000fd5 23456780 00000001
1 2 80000000 0000001f 00000fd5 ffffffff 00000084
1 2 f0000010 00000004 00000fd5 ff000001 00000080
1 2 12345678 00000021 00000fd5 091a2b3c 00000004
1 2 12345678 0000001f 00000fd5 00000000 00000044
0 0 123456b5 00000000 00000ad5 000000b5 00000ad5
1 1 abcd8421 00000020 00000246 00008421 00000246
0 2 deadbeef 00000040 00000893 deadbeef 00000893
1 2 80000000 ffffffe0 00000001 80000000 00000001
1 0 00000080 00000060 00000000 00000080 00000000

// ==== compile.f ====
rtl/x86_flags_pkg.sv
rtl/shift_pkg.sv
rtl/shift_core.sv
rtl/flag_gen.sv
rtl/shifter32.sv
rtl/shift_exec_stage.sv
rtl/shift_unit_top.sv
verification/tb_shift_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the shift unit testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_shift_unit \
	-f compile.f -Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vtb_shift_unit > sim.log 2>&1 \
	|| echo "Build or simulation returned an error, see build.log and sim.log"
grep -qx "TEST OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/tb_shift_unit.sv ====
/*
 * Shift unit testbench
 * Replays the golden vectors and random left shifts over the req/ack handshake
 */
`timescale 1ns/1ps

module tb_shift_unit;
	import shift_pkg::*;
	import x86_flags_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 8;
	localparam int RANDOM_OPS    = 20;
	localparam int CYCLES_PER_OP = 50;
	localparam int HOLD_CYCLES   = 10;

	logic       clk;
	logic       rst_n;
	logic       req;
	logic       ack;
	shift_dir_e dir;
	datasize_e  datasize;
	word_t      a;
	word_t      b;
	eflags_t    flags_in;
	word_t      result;
	eflags_t    flags_out;

	// One entry per golden line, element 0 is dir up to element 6 the flags
	logic [6:0][31:0] vectors[$];
	int               ops_total;

	shift_unit_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.ack       (ack),
		.dir       (dir),
		.datasize  (datasize),
		.a         (a),
		.b         (b),
		.flags_in  (flags_in),
		.result    (result),
		.flags_out (flags_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Inputs change 1 ns after the edge, outputs are settled by then
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_vectors();
		int               fd;
		int               n;
		string            line;
		logic [31:0]      f0, f1, f2, f3, f4, f5, f6;
		fd = $fopen("verification/shift_unit_golden.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open the golden file verification/shift_unit_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Skip comment and empty lines
				if (n > 1 && line.getc(0) != 8'h23) begin
					n = $sscanf(line, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
					if (n == 7)
						vectors.push_back({f6, f5, f4, f3, f2, f1, f0});
				end
			end
			$fclose(fd);
		end
	endtask

	// Full four-phase transfer, hold adds back-pressure cycles with ack high
	task automatic run_handshake(input shift_dir_e op_dir, input datasize_e op_size,
		input word_t op_a, input word_t op_b, input eflags_t op_flags, input int hold,
		output word_t res, output eflags_t flg);
		int edges;
		compare("ack before req", 32'd0, {31'd0, ack});
		dir      = op_dir;
		datasize = op_size;
		a        = op_a;
		b        = op_b;
		flags_in = op_flags;
		req      = 1'b1;
		edges    = 0;
		do begin
			next_cycle();
			edges++;
		end while (!ack && edges < CYCLES_PER_OP);
		if (!ack) begin
			abort_run("The unit never raised ack after req went high");
		end else begin
			// Capture edge plus the result edge
			compare("ack latency", 32'd2, edges);
			res = result;
			flg = flags_out;
			repeat (hold) begin
				next_cycle();
				compare("ack under back-pressure", 32'd1, {31'd0, ack});
				compare("result under back-pressure", res, result);
				compare("flags_out under back-pressure", flg, flags_out);
			end
			req = 1'b0;
			next_cycle();
			compare("ack after req low", 32'd0, {31'd0, ack});
			// Idle cycle, ack must not come back on its own
			next_cycle();
			compare("ack while idle", 32'd0, {31'd0, ack});
		end
	endtask

	// --------------------
	// Watchdog
	// --------------------
	initial begin
		wait (ops_total > 0);
		#(ops_total * CYCLES_PER_OP * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
		$display("Watchdog expired, the req/ack handshake hung");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		logic [6:0][31:0] v;
		logic [31:0]      lcg_state;
		word_t            ra;
		word_t            rb;
		word_t            res;
		eflags_t          flg;
		rst_n     = 1'b0;
		req       = 1'b0;
		dir       = DIR_LEFT;
		datasize  = SIZE_8;
		a         = '0;
		b         = '0;
		flags_in  = '0;
		ops_total = 0;
		load_vectors();
		ops_total = vectors.size() + RANDOM_OPS;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Reset state of the outputs
		compare("ack after reset", 32'd0, {31'd0, ack});
		compare("result after reset", 32'd0, result);
		compare("flags_out after reset", 32'd0, flags_out);
		next_cycle();

		foreach (vectors[i]) begin
			v = vectors[i];
			run_handshake(shift_dir_e'(v[0][0]), datasize_e'(v[1][1:0]), v[2], v[3], v[4],
				0, res, flg);
			compare($sformatf("result line %0d", i), v[5], res);
			compare($sformatf("flags_out line %0d", i), v[6], flg);
		end

		// Random left shifts check only handshake timing and back-pressure
		lcg_state = 32'd41712;
		repeat (RANDOM_OPS) begin
			lcg_state = lcg_next(lcg_state);
			ra        = lcg_state;
			lcg_state = lcg_next(lcg_state);
			rb        = lcg_state;
			run_handshake(DIR_LEFT, SIZE_32, ra, rb, '0, HOLD_CYCLES, res, flg);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

// ==== rtl/shift_unit_top.sv ====
/*
 * Shift unit top level
 * Connects the execute stage to the outside ports
 */
`timescale 1ns/1ps

module shift_unit_top (
	// Clock and synchronous reset
	input  logic                   clk,
	input  logic                   rst_n,

	// Four-phase handshake
	input  logic                   req,
	output logic                   ack,

	// Operation inputs, held stable while req is high
	input  shift_pkg::shift_dir_e  dir,
	input  shift_pkg::datasize_e   datasize,
	input  shift_pkg::word_t       a,
	input  shift_pkg::word_t       b,
	input  x86_flags_pkg::eflags_t flags_in,

	// Results, valid while ack is high
	output shift_pkg::word_t       result,
	output x86_flags_pkg::eflags_t flags_out
);

	// --------------------
	// Execute stage
	// --------------------
	shift_exec_stage u_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.ack       (ack),
		.dir       (dir),
		.datasize  (datasize),
		.a         (a),
		.b         (b),
		.flags_in  (flags_in),
		.result    (result),
		.flags_out (flags_out)
	);

endmodule

// ==== rtl/shift_exec_stage.sv ====
/*
 * Shift execute stage
 * Four-phase req/ack controller with operand and result registers
 */
`timescale 1ns/1ps

module shift_exec_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req,
	output logic                   ack,
	input  shift_pkg::shift_dir_e  dir,
	input  shift_pkg::datasize_e   datasize,
	input  shift_pkg::word_t       a,
	input  shift_pkg::word_t       b,
	input  x86_flags_pkg::eflags_t flags_in,
	output shift_pkg::word_t       result,
	output x86_flags_pkg::eflags_t flags_out
);
	import shift_pkg::*;
	import x86_flags_pkg::*;

	// Handshake FSM
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		EXEC = 2'd1,
		DONE = 2'd2
	} state_e;

	state_e     state;
	logic       capture;
	shift_dir_e dir_q;
	datasize_e  datasize_q;
	word_t      a_q;
	word_t      b_q;
	eflags_t    flags_q;
	word_t      shift_result;
	eflags_t    shift_flags;

	// Edge 1 of an operation
	assign capture = (state == IDLE) && req;

	// --------------------
	// Operand registers
	// --------------------
	always_ff @(posedge clk) begin
		if (capture) begin
			dir_q      <= dir;
			datasize_q <= datasize;
			a_q        <= a;
			b_q        <= b;
			flags_q    <= flags_in;
		end
	end

	shifter32 u_shifter (.dir(dir_q), .a(a_q), .b(b_q), .datasize(datasize_q),
		.flags_fwd(flags_q), .shift_result(shift_result), .shift_flags(shift_flags));

	// --------------------
	// FSM and result registers
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			result    <= '0;
			flags_out <= '0;
		end else begin
			case (state)
				IDLE: if (req) state <= EXEC;
				// Result lands together with ack on edge 2
				EXEC: begin
					result    <= shift_result;
					flags_out <= shift_flags;
					state     <= DONE;
				end
				// Hold the result until the requester lets go
				DONE: if (!req) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign ack = (state == DONE);

	// Ack only answers a request seen on the edge that raised it
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req));

	// Captured operands still match what the requester holds while in flight
	a_operands_held: assert property (@(posedge clk) disable iff (!rst_n)
		(state == EXEC) |->
		({dir, datasize, a, b, flags_in} == {dir_q, datasize_q, a_q, b_q, flags_q}));

endmodule

// ==== rtl/shifter32.sv ====
/*
 * 32-bit shifter
 * Computes SAL and SAR in parallel and selects by direction
 */
`timescale 1ns/1ps

module shifter32 (
	input  shift_pkg::shift_dir_e  dir,
	input  shift_pkg::word_t       a,
	input  shift_pkg::word_t       b,
	input  shift_pkg::datasize_e   datasize,
	input  x86_flags_pkg::eflags_t flags_fwd,
	output shift_pkg::word_t       shift_result,
	output x86_flags_pkg::eflags_t shift_flags
);
	import shift_pkg::*;
	import x86_flags_pkg::*;

	count_t  count;
	word_t   left_result;
	word_t   right_result;
	logic    left_carry;
	logic    right_carry;
	eflags_t left_flags;
	eflags_t right_flags;

	// x86 keeps only the low five count bits at every operand size
	assign count = b[COUNT_MASK_BITS-1:0];

	// --------------------
	// Left and right paths
	// --------------------
	shift_core u_sal (.a(a), .count(count), .datasize(datasize), .dir(DIR_LEFT),
		.result(left_result), .carry(left_carry));
	shift_core u_sar (.a(a), .count(count), .datasize(datasize), .dir(DIR_RIGHT),
		.result(right_result), .carry(right_carry));

	flag_gen u_sal_flags (.a(a), .result(left_result), .carry(left_carry),
		.datasize(datasize), .dir(DIR_LEFT), .flags(left_flags));
	flag_gen u_sar_flags (.a(a), .result(right_result), .carry(right_carry),
		.datasize(datasize), .dir(DIR_RIGHT), .flags(right_flags));

	// Zero count still limits the result to the operand size
	assign shift_result = (dir == DIR_LEFT) ? left_result : right_result;

	// Zero count leaves the flags as forwarded
	assign shift_flags = (count == '0) ? flags_fwd
		: ((dir == DIR_LEFT) ? left_flags : right_flags);

	// Size code 3 has no meaning in this unit
	always_comb begin
		assert (datasize !== 2'd3)
			else $error("shifter32 got illegal datasize 3");
	end

endmodule

// ==== rtl/flag_gen.sv ====
/*
 * Shift flag generator
 * Builds OF, SF, ZF, PF and CF into an EFLAGS word
 */
`timescale 1ns/1ps

module flag_gen (
	input  shift_pkg::word_t        a,
	input  shift_pkg::word_t        result,
	input  logic                    carry,
	input  shift_pkg::datasize_e    datasize,
	input  shift_pkg::shift_dir_e   dir,
	output x86_flags_pkg::eflags_t  flags
);
	import shift_pkg::*;
	import x86_flags_pkg::*;

	logic sf;
	logic zf;
	logic pf;
	// OF for a left shift before the direction select
	logic of_left;
	logic of;

	// --------------------
	// Size dependent flags
	// --------------------
	always_comb begin
		case (datasize)
			SIZE_8: begin
				sf      = result[7];
				zf      = (result[7:0] == 8'h00);
				of_left = a[7] ^ a[6];
			end
			SIZE_16: begin
				sf      = result[15];
				zf      = (result[15:0] == 16'h0000);
				of_left = a[15] ^ a[14];
			end
			default: begin
				sf      = result[31];
				zf      = (result == 32'h0000_0000);
				of_left = a[31] ^ a[30];
			end
		endcase
	end

	// Parity only ever looks at the low byte
	assign pf = ~^result[7:0];

	// Right shifts never flag overflow
	assign of = (dir == DIR_LEFT) ? of_left : 1'b0;

	// --------------------
	// Flag word assembly
	// --------------------
	always_comb begin
		flags         = '0;
		flags[CF_BIT] = carry;
		flags[PF_BIT] = pf;
		// AF undefined for shifts, decode masks it out
		flags[AF_BIT] = 1'b0;
		flags[ZF_BIT] = zf;
		flags[SF_BIT] = sf;
		flags[DF_BIT] = 1'b0;
		flags[OF_BIT] = of;
	end

endmodule

// ==== rtl/shift_core.sv ====
/*
 * Shift core
 * Sized arithmetic shift in one direction with the carry out
 */
`timescale 1ns/1ps

module shift_core (
	input  shift_pkg::word_t      a,
	input  shift_pkg::count_t     count,
	input  shift_pkg::datasize_e  datasize,
	input  shift_pkg::shift_dir_e dir,
	output shift_pkg::word_t      result,
	output logic                  carry
);
	import shift_pkg::*;

	word_t width_mask;
	// Operand zero-extended at its size
	word_t a_lim;
	// Operand sign-extended from its top bit
	word_t a_sx;
	// Left path, bit w of it holds the last bit shifted out
	logic [63:0] shl_ext;
	// Right path with one guard bit below bit 0 for the carry
	logic signed [32:0] sar_ext;
	logic left_carry;

	// --------------------
	// Operand sizing
	// --------------------
	always_comb begin
		case (datasize)
			SIZE_8: begin
				width_mask = 32'h0000_00ff;
				a_sx       = {{24{a[7]}}, a[7:0]};
			end
			SIZE_16: begin
				width_mask = 32'h0000_ffff;
				a_sx       = {{16{a[15]}}, a[15:0]};
			end
			default: begin
				width_mask = 32'hffff_ffff;
				a_sx       = a;
			end
		endcase
	end

	assign a_lim = a & width_mask;

	// --------------------
	// Both shifts
	// --------------------

	// Zeros come in from the right, bits above w are discarded later
	assign shl_ext = {32'b0, a_lim} << count;

	// Sign fills from the left, counts past w leave only sign bits
	assign sar_ext = $signed({a_sx, 1'b0}) >>> count;

	// Bit w of the left path is a[w-n] for 1..w and zero otherwise
	always_comb begin
		case (datasize)
			SIZE_8:  left_carry = shl_ext[8];
			SIZE_16: left_carry = shl_ext[16];
			default: left_carry = shl_ext[32];
		endcase
	end

	// Result limited back to the operand size
	assign result = (dir == DIR_LEFT) ? (shl_ext[31:0] & width_mask)
		: (sar_ext[32:1] & width_mask);
	assign carry  = (dir == DIR_LEFT) ? left_carry : sar_ext[0];

endmodule

// ==== rtl/shift_pkg.sv ====
/*
 * Shift unit types
 * Operand, count and size types plus the shift direction encoding
 */
package shift_pkg;

	// Low bits of b that form the x86 shift count
	localparam int COUNT_MASK_BITS = 5;

	// Operand or result word
	typedef logic [31:0] word_t;

	// Masked shift count
	typedef logic [COUNT_MASK_BITS-1:0] count_t;

	// Operand size, value 3 is illegal
	typedef enum logic [1:0] {
		SIZE_8  = 2'd0,
		SIZE_16 = 2'd1,
		SIZE_32 = 2'd2
	} datasize_e;

	// Shift direction
	typedef enum logic {
		DIR_LEFT  = 1'b0,
		DIR_RIGHT = 1'b1
	} shift_dir_e;

endpackage

// ==== rtl/x86_flags_pkg.sv ====
/*
 * x86 flag definitions
 * EFLAGS bit positions and the flag word type shared by the shift unit
 */
package x86_flags_pkg;

	// --------------------
	// Flag word
	// --------------------

	// Full EFLAGS register width
	typedef logic [31:0] eflags_t;

	// --------------------
	// Bit positions
	// --------------------

	// Carry out of the last shifted bit
	localparam int CF_BIT = 0;

	// Even parity of the low result byte
	localparam int PF_BIT = 2;

	// Auxiliary carry, left undefined by shifts
	localparam int AF_BIT = 4;

	// Result equal to zero at operand size
	localparam int ZF_BIT = 6;

	// Top bit of the result at operand size
	localparam int SF_BIT = 7;

	// String direction, never touched by the shifter
	localparam int DF_BIT = 10;

	// Sign change on a left shift
	localparam int OF_BIT = 11;

	// Bits not listed above stay zero in every computed word
	// Bit 1 is reserved as one in real EFLAGS, but the decode stage merges it

endpackage
